//--- verif/soc_ctrl_tests.txt
# op W: address data | R: address expected | G: gpio_in | I: irq level (0/1)
# op L: uart line (0 txd, 1 rxd) | H: hard reset, no args | all values hex
# registers, id, readback and unmapped reads
R 00001010 58343031
W 00001004 00002a5b
R 00001004 00002a5b
W 00001004 ffffffff
R 00001004 00003fff
R 00002000 00000000
R 00000010 00000000
R 00001014 00000000
R 00001018 00000000
# gpio inputs
G 000000a5
R 00001000 000000a5
G 00001f3c
R 00001000 00001f3c
# interrupts, mask bit 2 only
W 00001008 00000004
R 00001008 00000004
G 00001f38
I 1
R 0000100c 00000004
W 0000100c 00000004
I 0
R 0000100c 00000000
G 00001f3a
I 0
R 0000100c 00000000
# activity leds
L 1
L 0
# hard reset clears outputs and mask
H
R 00001004 00000000
R 00001008 00000000
R 00001010 58343031

//--- soc_ctrl_top.f
+incdir+include
hw/soc_ctrl_pkg.sv
hw/reset_gen.sv
hw/wb_csr_bridge.sv
hw/sysctl_regs.sv
hw/activity_stretch.sv
hw/soc_ctrl_top.sv
verif/soc_ctrl_tb.sv

//--- Bender.yml
package:
  name: soc_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - hw/soc_ctrl_pkg.sv
      - hw/reset_gen.sv
      - hw/wb_csr_bridge.sv
      - hw/sysctl_regs.sv
      - hw/activity_stretch.sv
      - hw/soc_ctrl_top.sv
  - target: test
    files:
      - verif/soc_ctrl_tb.sv

//--- verif/soc_ctrl_tb.sv
/*
 * Testbench for the system-control top level.
 * Reads its vectors from verif/soc_ctrl_tests.txt, so run from the project root.
 * Inputs change on rising edges, outputs are sampled on falling edges.
 * Stops at the first mismatch. A cycle counter bounds the whole run.
 */
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module soc_ctrl_tb;
	import soc_ctrl_pkg::*;

	localparam string TEST_FILE = "verif/soc_ctrl_tests.txt";
	localparam int N_RAND = 4;
	// Byte addresses of the system controller registers
	localparam logic [31:0] ADR_GPIO_IN  = {16'd0, `SOC_BANK_SYSCTL, `SOC_REG_GPIO_IN, 2'b00};
	localparam logic [31:0] ADR_GPIO_OUT = {16'd0, `SOC_BANK_SYSCTL, `SOC_REG_GPIO_OUT, 2'b00};
	localparam logic [31:0] ADR_HARD_RST = {16'd0, `SOC_BANK_SYSCTL, `SOC_REG_HARD_RST, 2'b00};

	logic        sys_clk;
	logic        rst_i;
	logic [31:0] wb_adr;
	csr_data_t   wb_dat_w;
	csr_data_t   wb_dat_r;
	logic        wb_we;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_ack;
	gpio_in_t    gpio_in;
	logic        uart_rxd;
	logic        uart_txd;
	logic [3:0]  led;
	logic [4:0]  btnled;
	logic        lcd_e;
	logic        lcd_rs;
	logic        lcd_rw;
	logic [3:0]  lcd_d;
	logic        gpio_irq;
	logic        soc_rst;
	logic        flash_rst_n;
	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit = 32'hffff_ffff;
	int          seed;

	soc_ctrl_top soc_ctrl_top_i (
		.sys_clk       (sys_clk),
		.rst_i         (rst_i),
		.wb_adr_i      (wb_adr),
		.wb_dat_i      (wb_dat_w),
		.wb_dat_o      (wb_dat_r),
		.wb_we_i       (wb_we),
		.wb_cyc_i      (wb_cyc),
		.wb_stb_i      (wb_stb),
		.wb_ack_o      (wb_ack),
		.gpio_in_i     (gpio_in),
		.uart_rxd_i    (uart_rxd),
		.uart_txd_i    (uart_txd),
		.led_o         (led),
		.btnled_o      (btnled),
		.lcd_e_o       (lcd_e),
		.lcd_rs_o      (lcd_rs),
		.lcd_rw_o      (lcd_rw),
		.lcd_d_o       (lcd_d),
		.gpio_irq_o    (gpio_irq),
		.soc_rst_o     (soc_rst),
		.flash_rst_n_o (flash_rst_n)
	);

	// 8 ns period
	initial sys_clk = 1'b0;
	always #4 sys_clk = ~sys_clk;

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit)
			abort_with("run exceeded its cycle limit");
	end

	// ----------------------------------------------------------------------
	// Reporting and compare helpers
	// ----------------------------------------------------------------------
	task automatic end_with_failure();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic abort_with(input string what);
		$display("%0t ns: %s", $time, what);
		end_with_failure();
	endtask

	task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
		if (got !== exp) begin
			$display("FAILED %0t ns: %s = %h, expected %h", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic check_gpio_out(input string name, input gpio_out_u got, input gpio_out_u exp);
		if (got !== exp) begin
			$display("FAILED %0t ns: %s = %h, expected %h", $time, name, got.raw, exp.raw);
			end_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %0t ns: %s = %b, expected %b", $time, name, got, exp);
			end_with_failure();
		end
	endtask

	task automatic need_args(input int code, input int n);
		if (code != n)
			abort_with("malformed line in the test file");
	endtask

	// Pins gathered back into the GPIO output word
	function automatic gpio_out_u pin_word();
		gpio_out_u w;
		w.fld.user_led = led[3:2];
		w.fld.btnled   = btnled;
		w.fld.lcd_e    = lcd_e;
		w.fld.lcd_rs   = lcd_rs;
		w.fld.lcd_rw   = lcd_rw;
		w.fld.lcd_d    = lcd_d;
		return w;
	endfunction

	// ----------------------------------------------------------------------
	// Bus and sequence tasks
	// ----------------------------------------------------------------------
	task automatic wb_access(input logic [31:0] adr, input logic we, input csr_data_t wdat,
		output csr_data_t rdat);
		int waited;
		@(posedge sys_clk);
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		wb_we    <= we;
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		waited = 0;
		do begin
			@(negedge sys_clk);
			waited++;
			if (waited > 16)
				abort_with("no Wishbone ack within 16 cycles");
		end while (!wb_ack);
		rdat = wb_dat_r;
		// Master drops the cycle right after ack
		@(posedge sys_clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic reset_sequence();
		int waited;
		logic flash_early;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		check_bit("soc_rst_o", soc_rst, 1'b1);
		check_bit("flash_rst_n_o", flash_rst_n, 1'b0);
		@(posedge sys_clk);
		rst_i <= 1'b0;
		waited = 0;
		flash_early = 1'b0;
		// Flash has to come up while the system is still held
		do begin
			@(negedge sys_clk);
			waited++;
			if (waited > `SOC_RST_HOLD + 4)
				abort_with("soc_rst_o still high after the reset hold");
			if (soc_rst && flash_rst_n)
				flash_early = 1'b1;
		end while (soc_rst);
		if (!flash_early)
			abort_with("flash reset not released before the system reset");
		check_bit("flash_rst_n_o", flash_rst_n, 1'b1);
		check_bit("wb_ack_o", wb_ack, 1'b0);
		check_bit("gpio_irq_o", gpio_irq, 1'b0);
		check_bit("led_o[0]", led[0], 1'b0);
		check_bit("led_o[1]", led[1], 1'b0);
		check_gpio_out("gpio output pins", pin_word(), '0);
	endtask

	task automatic pulse_uart(input logic [31:0] sel);
		int waited;
		@(posedge sys_clk);
		if (sel[0])
			uart_rxd <= 1'b0;
		else
			uart_txd <= 1'b0;
		@(posedge sys_clk);
		uart_rxd <= 1'b1;
		uart_txd <= 1'b1;
		waited = 0;
		do begin
			@(negedge sys_clk);
			waited++;
			if (waited > 2)
				abort_with("activity LED did not light within 2 cycles");
		end while (!led[sel[0]]);
		// Hold phase, the other LED stays dark
		do begin
			@(negedge sys_clk);
			waited++;
			check_bit(sel[0] ? "led_o[0]" : "led_o[1]", led[!sel[0]], 1'b0);
			if (waited > `SOC_ACT_HOLD + 4)
				abort_with("activity LED still lit after its hold time");
		end while (led[sel[0]]);
		if (waited < `SOC_ACT_HOLD)
			abort_with("activity LED went dark before its hold time");
	endtask

	task automatic hard_reset_check();
		csr_data_t rd_dummy;
		int waited;
		logic seen_rst;
		wb_access(ADR_HARD_RST, 1'b1, 32'h0, rd_dummy);
		waited = 0;
		seen_rst = 1'b0;
		do begin
			@(negedge sys_clk);
			waited++;
			check_bit("flash_rst_n_o", flash_rst_n, 1'b1);
			if (soc_rst)
				seen_rst = 1'b1;
			if (waited > `SOC_RST_HOLD + 8)
				abort_with("hard reset did not raise and then release soc_rst_o");
		end while (!seen_rst || soc_rst);
		check_gpio_out("gpio output pins", pin_word(), '0);
		check_bit("gpio_irq_o", gpio_irq, 1'b0);
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial begin : main
		int fd;
		int ch;
		int n_lines;
		int code;
		int k;
		logic [7:0] op;
		logic [31:0] arg_a;
		logic [31:0] arg_b;
		logic [31:0] rnd_word;
		csr_data_t rd;
		csr_data_t exp_rd;
		gpio_out_u exp_out;
		gpio_in_t rnd_in;
		// Idle bus, UART lines idle high
		rst_i    <= 1'b1;
		wb_adr   <= '0;
		wb_dat_w <= '0;
		wb_we    <= 1'b0;
		wb_cyc   <= 1'b0;
		wb_stb   <= 1'b0;
		gpio_in  <= '0;
		uart_rxd <= 1'b1;
		uart_txd <= 1'b1;
		seed = 32'h3fa1_ec58;
		// Line count sizes the timeout
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0)
			abort_with("cannot open the test vector file");
		n_lines = 0;
		ch = $fgetc(fd);
		while (ch != -1) begin
			if (ch == "\n")
				n_lines++;
			ch = $fgetc(fd);
		end
		$fclose(fd);
		cycle_limit = (n_lines + N_RAND) * 64 + 200;
		reset_sequence();
		fd = $fopen(TEST_FILE, "r");
		code = $fscanf(fd, " %c", op);
		while (code == 1) begin
			case (op)
				"#": begin
					ch = $fgetc(fd);
					while (ch != "\n" && ch != -1)
						ch = $fgetc(fd);
				end
				"W": begin
					need_args($fscanf(fd, "%h %h", arg_a, arg_b), 2);
					wb_access(arg_a, 1'b1, arg_b, rd);
					// Pins must follow the union fields of the written word
					if (arg_a == ADR_GPIO_OUT) begin
						exp_out.raw = arg_b[`SOC_GPIO_OUT_W-1:0];
						check_gpio_out("gpio output pins", pin_word(), exp_out);
					end
				end
				"R": begin
					need_args($fscanf(fd, "%h %h", arg_a, arg_b), 2);
					wb_access(arg_a, 1'b0, '0, rd);
					check_data($sformatf("wb_dat_o @ %08h", arg_a), rd, arg_b);
				end
				"G": begin
					need_args($fscanf(fd, "%h", arg_a), 1);
					@(posedge sys_clk);
					gpio_in <= arg_a[`SOC_GPIO_IN_W-1:0];
				end
				"I": begin
					need_args($fscanf(fd, "%h", arg_a), 1);
					// Two sync stages plus edge detect, with margin
					repeat (6) @(negedge sys_clk);
					check_bit("gpio_irq_o", gpio_irq, arg_a[0]);
				end
				"L": begin
					need_args($fscanf(fd, "%h", arg_a), 1);
					pulse_uart(arg_a);
				end
				"H": hard_reset_check();
				default: abort_with("unknown opcode in the test file");
			endcase
			code = $fscanf(fd, " %c", op);
		end
		$fclose(fd);
		// Extra input readbacks from the seeded generator
		for (k = 0; k < N_RAND; k++) begin
			rnd_word = $random(seed);
			rnd_in = rnd_word[`SOC_GPIO_IN_W-1:0];
			@(posedge sys_clk);
			gpio_in <= rnd_in;
			repeat (4) @(posedge sys_clk);
			wb_access(ADR_GPIO_IN, 1'b0, '0, rd);
			exp_rd = '0;
			exp_rd[`SOC_GPIO_IN_W-1:0] = rnd_in;
			check_data("wb_dat_o gpio_in", rd, exp_rd);
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- hw/soc_ctrl_top.sv
/*
 * System-control top: reset generation, Wishbone to CSR bridge,
 * system controller bank and UART activity LEDs.
 * Single Wishbone master, one transaction at a time.
 * UART lines are monitored only, idle high.
 */
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module soc_ctrl_top (
	input  logic                    sys_clk,
	input  logic                    rst_i,
	input  logic [`SOC_WB_DW-1:0]   wb_adr_i,
	input  soc_ctrl_pkg::csr_data_t wb_dat_i,
	output soc_ctrl_pkg::csr_data_t wb_dat_o,
	input  logic                    wb_we_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	output logic                    wb_ack_o,
	input  soc_ctrl_pkg::gpio_in_t  gpio_in_i,
	input  logic                    uart_rxd_i,
	input  logic                    uart_txd_i,
	output logic [3:0]              led_o,
	output logic [4:0]              btnled_o,
	output logic                    lcd_e_o,
	output logic                    lcd_rs_o,
	output logic                    lcd_rw_o,
	output logic [3:0]              lcd_d_o,
	output logic                    gpio_irq_o,
	output logic                    soc_rst_o,
	output logic                    flash_rst_n_o
);
	import soc_ctrl_pkg::*;

	logic      soc_rst;
	logic      hard_rst_req;
	csr_addr_t csr_a;
	logic      csr_we;
	csr_data_t csr_dw;
	csr_data_t csr_dr;
	gpio_out_u gpio_out;
	logic      tx_led;
	logic      rx_led;

	// ------------------------------------------------------------------
	// Reset
	// ------------------------------------------------------------------
	reset_gen reset_gen_i (
		.sys_clk        (sys_clk),
		.rst_i          (rst_i),
		.hard_rst_req_i (hard_rst_req),
		.soc_rst_o      (soc_rst),
		.flash_rst_n_o  (flash_rst_n_o)
	);

	assign soc_rst_o = soc_rst;

	// ------------------------------------------------------------------
	// Wishbone to CSR
	// ------------------------------------------------------------------
	wb_csr_bridge wb_csr_bridge_i (
		.sys_clk  (sys_clk),
		.rst_i    (soc_rst),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_we_i  (wb_we_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_ack_o (wb_ack_o),
		.csr_a_o  (csr_a),
		.csr_we_o (csr_we),
		.csr_dw_o (csr_dw),
		.csr_dr_i (csr_dr)
	);

	// Only bank on the bus, so no read OR
	sysctl_regs sysctl_regs_i (
		.sys_clk        (sys_clk),
		.rst_i          (soc_rst),
		.csr_a_i        (csr_a),
		.csr_we_i       (csr_we),
		.csr_dw_i       (csr_dw),
		.csr_dr_o       (csr_dr),
		.gpio_in_i      (gpio_in_i),
		.gpio_out_o     (gpio_out),
		.gpio_irq_o     (gpio_irq_o),
		.hard_rst_req_o (hard_rst_req)
	);

	// ------------------------------------------------------------------
	// UART activity LEDs
	// ------------------------------------------------------------------
	activity_stretch tx_stretch_i (
		.sys_clk (sys_clk),
		.rst_i   (soc_rst),
		.line_i  (uart_txd_i),
		.led_o   (tx_led)
	);

	activity_stretch rx_stretch_i (
		.sys_clk (sys_clk),
		.rst_i   (soc_rst),
		.line_i  (uart_rxd_i),
		.led_o   (rx_led)
	);

	// LED0 tx, LED1 rx, upper two under software control
	assign led_o    = {gpio_out.fld.user_led, rx_led, tx_led};
	assign btnled_o = gpio_out.fld.btnled;
	assign lcd_e_o  = gpio_out.fld.lcd_e;
	assign lcd_rs_o = gpio_out.fld.lcd_rs;
	assign lcd_rw_o = gpio_out.fld.lcd_rw;
	assign lcd_d_o  = gpio_out.fld.lcd_d;

endmodule

//--- hw/activity_stretch.sv
/*
 * Stretches low pulses on an idle-high serial line for an LED.
 * LED lights one cycle after the line goes low and stays on
 * SOC_ACT_HOLD cycles after the line is high again.
 */
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module activity_stretch (
	input  logic sys_clk,
	input  logic rst_i,
	input  logic line_i,
	output logic led_o
);
	localparam int CNT_W = $clog2(`SOC_ACT_HOLD + 1);

	logic [CNT_W-1:0] act_cnt;

	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			act_cnt <= '0;
			led_o   <= 1'b0;
		end else begin
			// Any low bit restarts the hold
			if (!line_i)
				act_cnt <= CNT_W'(`SOC_ACT_HOLD);
			else if (act_cnt != '0)
				act_cnt <= act_cnt - 1'b1;
			// Registered, so LED follows the count by a cycle
			led_o <= (act_cnt != '0);
		end
	end

endmodule

//--- hw/sysctl_regs.sv
/*
 * System controller CSR bank: GPIO, GPIO interrupt, system ID, hard reset.
 * GPIO inputs may be asynchronous, they pass two flops first.
 * Pending bits set 2 to 3 cycles after an input edge, write 1 to clear.
 * Reads of other banks return zero.
 */
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module sysctl_regs (
	input  logic                    sys_clk,
	input  logic                    rst_i,
	input  soc_ctrl_pkg::csr_addr_t csr_a_i,
	input  logic                    csr_we_i,
	input  soc_ctrl_pkg::csr_data_t csr_dw_i,
	output soc_ctrl_pkg::csr_data_t csr_dr_o,
	input  soc_ctrl_pkg::gpio_in_t  gpio_in_i,
	output soc_ctrl_pkg::gpio_out_u gpio_out_o,
	output logic                    gpio_irq_o,
	output logic                    hard_rst_req_o
);
	import soc_ctrl_pkg::*;

	logic [`SOC_CSR_BANK_W-1:0] csr_bank;
	logic [`SOC_CSR_REG_W-1:0]  csr_reg;
	logic                       bank_sel;
	logic                       reg_wr;
	gpio_in_t                   gpio_meta;
	gpio_in_t                   gpio_sync;
	gpio_in_t                   gpio_prev;
	gpio_in_t                   gpio_chg;
	gpio_in_t                   irq_mask;
	gpio_in_t                   irq_pend;
	gpio_in_t                   pend_clr;

	// ------------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------------
	assign csr_bank = csr_a_i[`SOC_CSR_AW-1 -: `SOC_CSR_BANK_W];
	assign csr_reg  = csr_a_i[`SOC_CSR_REG_W-1:0];
	assign bank_sel = (csr_bank == `SOC_BANK_SYSCTL);
	assign reg_wr   = bank_sel & csr_we_i;

	// ------------------------------------------------------------------
	// Input synchronizer and edge detect
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		gpio_meta <= gpio_in_i;
		gpio_sync <= gpio_meta;
		// One more stage only for change detection
		gpio_prev <= gpio_sync;
	end

	// Both edges count as a change
	assign gpio_chg = gpio_sync ^ gpio_prev;

	// Write-one-to-clear mask for the pending flags
	assign pend_clr = (reg_wr && (csr_reg == `SOC_REG_IRQ_PEND)) ?
		csr_dw_i[`SOC_GPIO_IN_W-1:0] : '0;

	// ------------------------------------------------------------------
	// Writable state
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			gpio_out_o     <= '0;
			irq_mask       <= '0;
			irq_pend       <= '0;
			hard_rst_req_o <= 1'b0;
		end else begin
			// New edge wins over a clear in the same cycle
			irq_pend <= (irq_pend & ~pend_clr) | (gpio_chg & irq_mask);
			// Data ignored, any write requests the reset
			hard_rst_req_o <= reg_wr && (csr_reg == `SOC_REG_HARD_RST);
			if (reg_wr) begin
				case (csr_reg)
					`SOC_REG_GPIO_OUT: gpio_out_o.raw <= csr_dw_i[`SOC_GPIO_OUT_W-1:0];
					`SOC_REG_IRQ_MASK: irq_mask <= csr_dw_i[`SOC_GPIO_IN_W-1:0];
					default: ;
				endcase
			end
		end
	end

	assign gpio_irq_o = |irq_pend;

	// ------------------------------------------------------------------
	// Read back, one cycle latency
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!bank_sel) begin
			csr_dr_o <= '0;
		end else begin
			case (csr_reg)
				`SOC_REG_GPIO_IN:  csr_dr_o <= csr_data_t'(gpio_sync);
				`SOC_REG_GPIO_OUT: csr_dr_o <= csr_data_t'(gpio_out_o.raw);
				`SOC_REG_IRQ_MASK: csr_dr_o <= csr_data_t'(irq_mask);
				`SOC_REG_IRQ_PEND: csr_dr_o <= csr_data_t'(irq_pend);
				`SOC_REG_SYSID:    csr_dr_o <= `SOC_SYSID;
				// Hard reset reads as zero, like unmapped offsets
				default:           csr_dr_o <= '0;
			endcase
		end
	end

endmodule

//--- hw/wb_csr_bridge.sv
/*
 * Wishbone classic slave to single-cycle CSR bus.
 * One transaction in flight, no burst, no byte selects.
 * Write ack two cycles after the request edge, read ack three.
 * Only address bits 15..2 reach the CSR bus.
 */
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module wb_csr_bridge (
	input  logic                    sys_clk,
	input  logic                    rst_i,
	input  logic [`SOC_WB_DW-1:0]   wb_adr_i,
	input  soc_ctrl_pkg::csr_data_t wb_dat_i,
	output soc_ctrl_pkg::csr_data_t wb_dat_o,
	input  logic                    wb_we_i,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	output logic                    wb_ack_o,
	output soc_ctrl_pkg::csr_addr_t csr_a_o,
	output logic                    csr_we_o,
	output soc_ctrl_pkg::csr_data_t csr_dw_o,
	input  soc_ctrl_pkg::csr_data_t csr_dr_i
);
	import soc_ctrl_pkg::*;

	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_STROBE = 2'd1;
	localparam logic [1:0] ST_RDWAIT = 2'd2;
	localparam logic [1:0] ST_ACK    = 2'd3;

	logic [1:0] state;
	logic       wb_start;

	// New request only accepted from idle
	assign wb_start = (state == ST_IDLE) & wb_cyc_i & wb_stb_i;

	// ------------------------------------------------------------------
	// Control FSM
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			state    <= ST_IDLE;
			csr_we_o <= 1'b0;
			wb_ack_o <= 1'b0;
		end else begin
			// Strobe and ack are single-cycle pulses
			csr_we_o <= 1'b0;
			wb_ack_o <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (wb_start) begin
						csr_we_o <= wb_we_i;
						state    <= ST_STROBE;
					end
				end
				ST_STROBE: begin
					// csr_we_o still high here means a write
					if (csr_we_o) begin
						wb_ack_o <= 1'b1;
						state    <= ST_ACK;
					end else begin
						state <= ST_RDWAIT;
					end
				end
				ST_RDWAIT: begin
					// Bank data registered last edge, valid now
					wb_ack_o <= 1'b1;
					state    <= ST_ACK;
				end
				default: begin
					// Master drops stb now, back to idle
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// Address and data path
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (wb_start) begin
			// Word address, byte lanes dropped
			csr_a_o  <= csr_addr_t'(wb_adr_i[`SOC_CSR_AW+1:2]);
			csr_dw_o <= wb_dat_i;
		end
		if (state == ST_RDWAIT)
			wb_dat_o <= csr_dr_i;
	end

	// Ack only answers a live master request
	assert property (@(posedge sys_clk) disable iff (rst_i)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i))
		else $error("ack without an active Wishbone cycle");

endmodule

//--- hw/reset_gen.sv
/*
 * System and flash reset generation.
 * rst_i is assumed synchronous to sys_clk already.
 * A hard-reset request restarts the system hold only, the flash
 * stays out of reset.
 */
`timescale 1ns/1ps
`include "soc_ctrl_defines.svh"

module reset_gen (
	input  logic sys_clk,
	input  logic rst_i,
	input  logic hard_rst_req_i,
	output logic soc_rst_o,
	output logic flash_rst_n_o
);
	import soc_ctrl_pkg::*;

	rst_cnt_t rst_cnt;
	rst_cnt_t flash_cnt;
	logic     soc_rst_q;

	// Flash has to wake up first
	if (`SOC_FLASH_RST_HOLD >= `SOC_RST_HOLD) begin : g_hold_check
		$error("flash reset hold must be shorter than the system reset hold");
	end

	// ------------------------------------------------------------------
	// System reset hold
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			rst_cnt   <= rst_cnt_t'(`SOC_RST_HOLD);
			soc_rst_q <= 1'b1;
		end else begin
			// Software hard reset reloads the hold
			if (hard_rst_req_i)
				rst_cnt <= rst_cnt_t'(`SOC_RST_HOLD);
			else if (rst_cnt != '0)
				rst_cnt <= rst_cnt - 1'b1;
			// Request counts as the first held cycle
			soc_rst_q <= (rst_cnt != '0) | hard_rst_req_i;
		end
	end

	assign soc_rst_o = soc_rst_q;

	// ------------------------------------------------------------------
	// Flash reset, released early
	// ------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (rst_i)
			flash_cnt <= '0;
		else if (flash_cnt != rst_cnt_t'(`SOC_FLASH_RST_HOLD))
			flash_cnt <= flash_cnt + 1'b1;
	end

	// Saturated count means flash may run
	assign flash_rst_n_o = (flash_cnt == rst_cnt_t'(`SOC_FLASH_RST_HOLD));

	// CPU must never fetch from a flash still in reset
	assert property (@(posedge sys_clk) disable iff (rst_i)
		$fell(soc_rst_o) |-> flash_rst_n_o)
		else $error("system reset released while flash is still in reset");

endmodule

//--- hw/soc_ctrl_pkg.sv
/*
 * Types shared by the CSR bridge, the system controller and the top.
 * The gpio_out_u field order follows the board pin map, LSB first
 * user LEDs, then button LEDs, then the LCD lines.
 */
`include "soc_ctrl_defines.svh"

package soc_ctrl_pkg;

	// CSR word address, bank on top and register offset below
	typedef logic [`SOC_CSR_AW-1:0] csr_addr_t;

	// One CSR data word, same width as the Wishbone data path
	typedef logic [`SOC_WB_DW-1:0] csr_data_t;

	// Raw GPIO inputs, buttons in the low bits
	typedef logic [`SOC_GPIO_IN_W-1:0] gpio_in_t;

	// Wide enough for the longest reset hold
	typedef logic [$clog2(`SOC_RST_HOLD + 1)-1:0] rst_cnt_t;

	// GPIO output word
	// Software sees raw, the board wiring sees fld
	typedef union packed {
		logic [`SOC_GPIO_OUT_W-1:0] raw;
		struct packed {
			logic [3:0] lcd_d;
			logic       lcd_rw;
			logic       lcd_rs;
			logic       lcd_e;
			logic [4:0] btnled;
			logic [1:0] user_led;
		} fld;
	} gpio_out_u;

endpackage

//--- include/soc_ctrl_defines.svh
/*
 * Widths, hold counts and the register map of the system-control block.
 * All hold counts are in sys_clk cycles.
 * SOC_FLASH_RST_HOLD has to stay below SOC_RST_HOLD, or the CPU side
 * leaves reset before the flash is readable.
 */
`ifndef SOC_CTRL_DEFINES_SVH
`define SOC_CTRL_DEFINES_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define SOC_WB_DW          32
`define SOC_CSR_AW         14
// Bank select sits on the top bits of the CSR word address
`define SOC_CSR_BANK_W     4
`define SOC_CSR_REG_W      10

// ----------------------------------------------------------------------
// System controller register map
// ----------------------------------------------------------------------
`define SOC_BANK_SYSCTL    4'd1
`define SOC_REG_GPIO_IN    10'd0
`define SOC_REG_GPIO_OUT   10'd1
`define SOC_REG_IRQ_MASK   10'd2
`define SOC_REG_IRQ_PEND   10'd3
`define SOC_REG_SYSID      10'd4
`define SOC_REG_HARD_RST   10'd5

// 8 DIP switches plus 5 buttons
`define SOC_GPIO_IN_W      13
// 2 user LEDs, 5 button LEDs, 7 LCD lines
`define SOC_GPIO_OUT_W     14

// ASCII "X401"
`define SOC_SYSID          32'h58343031

// ----------------------------------------------------------------------
// Hold times
// ----------------------------------------------------------------------
`define SOC_RST_HOLD       16
`define SOC_FLASH_RST_HOLD 8
`define SOC_ACT_HOLD       32

`endif
